/* src/isaPkg.sv */
// instruction-set definitions for the core
// word layout union, opcode and funct codes, register constants
`default_nettype none

package isaPkg;

   localparam int dataWidth = 32;
   localparam int regBits   = 5;

   localparam logic [regBits-1:0] linkReg = 5'd31; // jal writes here

   //----------------------------------------------------------------------
   // instruction word formats
   //----------------------------------------------------------------------
   typedef struct packed {
      logic [5:0] op;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } rFormat;

   typedef struct packed {
      logic [5:0]  op;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
   } iFormat;

   typedef struct packed {
      logic [5:0]  op;
      logic [25:0] target;
   } jFormat;

   // one fetched word seen three ways
   typedef union packed {
      rFormat rFields;
      iFormat iFields;
      jFormat jFields;
   } instrWord;

   //----------------------------------------------------------------------
   // opcodes
   //----------------------------------------------------------------------
   localparam logic [5:0] opRtype = 6'b000000;
   localparam logic [5:0] opLw    = 6'b100011;
   localparam logic [5:0] opSw    = 6'b101011;
   localparam logic [5:0] opBeq   = 6'b000100;
   localparam logic [5:0] opBne   = 6'b000101;
   localparam logic [5:0] opJ     = 6'b000010;
   localparam logic [5:0] opJal   = 6'b000011;
   localparam logic [5:0] opAddi  = 6'b001000;
   localparam logic [5:0] opAndi  = 6'b001100;
   localparam logic [5:0] opLui   = 6'b001111;

   // funct field of R-type
   localparam logic [5:0] fnAdd = 6'b100000;
   localparam logic [5:0] fnSub = 6'b100010;
   localparam logic [5:0] fnAnd = 6'b100100;
   localparam logic [5:0] fnOr  = 6'b100101;
   localparam logic [5:0] fnSll = 6'b000000;
   localparam logic [5:0] fnSrl = 6'b000010;
   localparam logic [5:0] fnJr  = 6'b001000;

endpackage

`default_nettype wire

/* src/ctrlPkg.sv */
// control definitions
// FSM states, ALU operations and datapath mux select codes
`default_nettype none

package ctrlPkg;

   // instruction phases of the multicycle FSM
   typedef enum logic [4:0] {
      sFetch,
      sDecode,
      sMemAdr,
      sLwRead,
      sLwWrite,
      sSwWrite,
      sRtypeEx,
      sRtypeWr,
      sImmEx,
      sImmWr,
      sBranchEx,
      sJump,
      sJalWr
   } ctrlState;

   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluSll,
      aluSrl,
      aluLui
   } aluOp;

   // how execUnit picks its operation
   typedef enum logic [1:0] {
      modeAdd,
      modeSub,
      modeFunct, // from funct field
      modeImm    // from opcode
   } aluMode;

   typedef enum logic [1:0] {srcBReg, srcBFour, srcBImm, srcBBranch} srcBSel;

   typedef enum logic [1:0] {pcAluResult, pcAluOut, pcJump} pcSel;

   typedef enum logic [1:0] {dstRt, dstRd, dstLink} regDstSel;

endpackage

`default_nettype wire

/* src/regFile.sv */
// 32-entry register file
// two combinational read ports, one clocked write port
`timescale 1ns/10ps
`default_nettype none

module regFile
(
   input  wire logic                         clk,
   input  wire logic                         reset,
   input  wire logic                         regWrite,
   input  wire logic [isaPkg::regBits-1:0]   readAdr1,
   input  wire logic [isaPkg::regBits-1:0]   readAdr2,
   input  wire logic [isaPkg::regBits-1:0]   writeAdr,
   input  wire logic [isaPkg::dataWidth-1:0] writeData,
   output logic [isaPkg::dataWidth-1:0]      readData1,
   output logic [isaPkg::dataWidth-1:0]      readData2
);

   logic [isaPkg::dataWidth-1:0] regs [2**isaPkg::regBits];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < 2**isaPkg::regBits; i++)
            regs[i] <= '0;
      end
      else if (regWrite)
         regs[writeAdr] <= writeData;
   end

   // register 0 is hardwired to zero
   assign readData1 = (readAdr1 == '0) ? '0 : regs[readAdr1];
   assign readData2 = (readAdr2 == '0) ? '0 : regs[readAdr2];

endmodule

`default_nettype wire

/* src/execUnit.sv */
// execute unit
// ALU-operation decode, ALU, zero flag and jr detect
`timescale 1ns/10ps
`default_nettype none

module execUnit
(
   input  wire ctrlPkg::aluMode             mode,
   input  wire logic [5:0]                  op,
   input  wire logic [5:0]                  funct,
   input  wire logic [4:0]                  shamt,
   input  wire logic [isaPkg::dataWidth-1:0] srcA,
   input  wire logic [isaPkg::dataWidth-1:0] srcB,
   output logic [isaPkg::dataWidth-1:0]      result,
   output logic                             zero,
   output logic                             jrTaken
);

   ctrlPkg::aluOp operation;

   // operation select
   always_comb
   begin
      operation = ctrlPkg::aluAdd;
      case (mode)
         ctrlPkg::modeSub:   operation = ctrlPkg::aluSub;
         ctrlPkg::modeFunct:
         begin
            case (funct)
               isaPkg::fnSub: operation = ctrlPkg::aluSub;
               isaPkg::fnAnd: operation = ctrlPkg::aluAnd;
               isaPkg::fnOr:  operation = ctrlPkg::aluOr;
               isaPkg::fnSll: operation = ctrlPkg::aluSll;
               isaPkg::fnSrl: operation = ctrlPkg::aluSrl;
               default:       operation = ctrlPkg::aluAdd; // add and jr
            endcase
         end
         ctrlPkg::modeImm:
         begin
            if (op == isaPkg::opAndi)
               operation = ctrlPkg::aluAnd;
            else if (op == isaPkg::opLui)
               operation = ctrlPkg::aluLui;
         end
         default:            operation = ctrlPkg::aluAdd;
      endcase
   end

   always_comb
   begin
      case (operation)
         ctrlPkg::aluSub: result = srcA - srcB;
         ctrlPkg::aluAnd: result = srcA & srcB;
         ctrlPkg::aluOr:  result = srcA | srcB;
         ctrlPkg::aluSll: result = srcB << shamt;  // rt moves, rs unused
         ctrlPkg::aluSrl: result = srcB >> shamt;
         ctrlPkg::aluLui: result = srcB << 16;
         default:         result = srcA + srcB;
      endcase
   end

   assign zero    = (result == '0);
   assign jrTaken = (mode == ctrlPkg::modeFunct) && (funct == isaPkg::fnJr);

endmodule

`default_nettype wire

/* src/mainControl.sv */
// instruction-phase FSM of the multicycle core
// next-phase selection, per-phase strobes and PC enable
`timescale 1ns/10ps
`default_nettype none

module mainControl
(
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic [5:0]        op,
   input  wire logic              zero,
   input  wire logic              jrTaken,
   output logic                   memRead,
   output logic                   memWrite,
   output logic                   irWrite,
   output logic                   regWrite,
   output logic                   memToReg,
   output logic                   iOrD,
   output logic                   srcASel,
   output ctrlPkg::regDstSel      regDst,
   output ctrlPkg::srcBSel        srcB,
   output ctrlPkg::pcSel          pcSource,
   output ctrlPkg::aluMode        mode,
   output logic                   pcEnable
);

   ctrlPkg::ctrlState state;
   ctrlPkg::ctrlState nextState;
   logic              pcWrite;
   logic              branchEq;
   logic              branchNe;

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= ctrlPkg::sFetch;
      else
         state <= nextState;
   end

   //----------------------------------------------------------------------
   // next phase
   //----------------------------------------------------------------------
   always_comb
   begin
      nextState = ctrlPkg::sFetch;
      case (state)
         ctrlPkg::sFetch:   nextState = ctrlPkg::sDecode;
         ctrlPkg::sDecode:
         begin
            case (op)
               isaPkg::opRtype:               nextState = ctrlPkg::sRtypeEx;
               isaPkg::opLw, isaPkg::opSw:    nextState = ctrlPkg::sMemAdr;
               isaPkg::opBeq, isaPkg::opBne:  nextState = ctrlPkg::sBranchEx;
               isaPkg::opJ:                   nextState = ctrlPkg::sJump;
               isaPkg::opJal:                 nextState = ctrlPkg::sJalWr;
               isaPkg::opAddi, isaPkg::opAndi,
               isaPkg::opLui:                 nextState = ctrlPkg::sImmEx;
               default:                       nextState = ctrlPkg::sFetch; // unknown op
            endcase
         end
         ctrlPkg::sMemAdr:
         begin
            if (op == isaPkg::opLw)
               nextState = ctrlPkg::sLwRead;
            else
               nextState = ctrlPkg::sSwWrite;
         end
         ctrlPkg::sLwRead:  nextState = ctrlPkg::sLwWrite;
         ctrlPkg::sRtypeEx: nextState = ctrlPkg::sRtypeWr;
         ctrlPkg::sImmEx:   nextState = ctrlPkg::sImmWr;
         ctrlPkg::sJalWr:   nextState = ctrlPkg::sJump; // link first, then jump
         default:           nextState = ctrlPkg::sFetch;
      endcase
   end

   //----------------------------------------------------------------------
   // per-phase strobes
   //----------------------------------------------------------------------
   always_comb
   begin
      memRead  = 1'b0;
      memWrite = 1'b0;
      irWrite  = 1'b0;
      regWrite = 1'b0;
      memToReg = 1'b0;
      iOrD     = 1'b0;
      srcASel  = 1'b0;       // pc
      pcWrite  = 1'b0;
      branchEq = 1'b0;
      branchNe = 1'b0;
      regDst   = ctrlPkg::dstRt;
      srcB     = ctrlPkg::srcBReg;
      pcSource = ctrlPkg::pcAluResult;
      mode     = ctrlPkg::modeAdd;
      case (state)
         ctrlPkg::sFetch:
         begin
            memRead = 1'b1;
            irWrite = 1'b1;
            srcB    = ctrlPkg::srcBFour; // pc + 4
            pcWrite = 1'b1;
         end
         // branch target lands in aluOut
         ctrlPkg::sDecode:  srcB = ctrlPkg::srcBBranch;
         ctrlPkg::sMemAdr:
         begin
            srcASel = 1'b1;
            srcB    = ctrlPkg::srcBImm;
         end
         ctrlPkg::sLwRead:
         begin
            memRead = 1'b1;
            iOrD    = 1'b1;
         end
         ctrlPkg::sLwWrite:
         begin
            regWrite = 1'b1;
            memToReg = 1'b1;
         end
         ctrlPkg::sSwWrite:
         begin
            memWrite = 1'b1;
            iOrD     = 1'b1;
         end
         ctrlPkg::sRtypeEx:
         begin
            srcASel = 1'b1;
            mode    = ctrlPkg::modeFunct; // jr also lands here
         end
         ctrlPkg::sRtypeWr:
         begin
            regDst   = ctrlPkg::dstRd;
            regWrite = 1'b1;
         end
         ctrlPkg::sImmEx:
         begin
            srcASel = 1'b1;
            srcB    = ctrlPkg::srcBImm;
            mode    = ctrlPkg::modeImm;
         end
         ctrlPkg::sImmWr:   regWrite = 1'b1;
         ctrlPkg::sBranchEx:
         begin
            srcASel  = 1'b1;
            mode     = ctrlPkg::modeSub;  // compare rs and rt
            pcSource = ctrlPkg::pcAluOut;
            branchEq = (op == isaPkg::opBeq);
            branchNe = (op == isaPkg::opBne);
         end
         ctrlPkg::sJump:
         begin
            pcWrite  = 1'b1;
            pcSource = ctrlPkg::pcJump;
         end
         ctrlPkg::sJalWr:
         begin
            regDst   = ctrlPkg::dstLink;  // writes pc, already +4
            regWrite = 1'b1;
         end
         default:           pcWrite = 1'b0;
      endcase
   end

   assign pcEnable = pcWrite | (branchEq & zero) | (branchNe & ~zero) | jrTaken;

endmodule

`default_nettype wire

/* src/datapath.sv */
// datapath of the multicycle core
// PC, IR, MDR, operand and ALU-out registers, immediates and source muxes
`timescale 1ns/10ps
`default_nettype none

module datapath
(
   input  wire logic                         clk,
   input  wire logic                         reset,
   input  wire logic [isaPkg::dataWidth-1:0] memReadData,
   input  wire logic                         irWrite,
   input  wire logic                         regWrite,
   input  wire logic                         memToReg,
   input  wire logic                         iOrD,
   input  wire logic                         srcASel,
   input  wire logic                         pcEnable,
   input  wire ctrlPkg::regDstSel            regDst,
   input  wire ctrlPkg::srcBSel              srcB,
   input  wire ctrlPkg::pcSel                pcSource,
   input  wire ctrlPkg::aluMode              mode,
   output logic [5:0]                        op,
   output logic                              zero,
   output logic                              jrTaken,
   output logic [isaPkg::dataWidth-1:0]      memAdr,
   output logic [isaPkg::dataWidth-1:0]      memWriteData
);

   isaPkg::instrWord             ir;
   logic [isaPkg::dataWidth-1:0] pc, pcNext;
   logic [isaPkg::dataWidth-1:0] mdr, aReg, bReg, aluOut;
   logic [isaPkg::dataWidth-1:0] readData1, readData2, aluResult;
   logic [isaPkg::dataWidth-1:0] srcAVal, srcBVal, writeData;
   logic [isaPkg::dataWidth-1:0] signImm, immExt, branchOff, jumpTarget;
   logic [isaPkg::regBits-1:0]   writeAdr;

   //----------------------------------------------------------------------
   // state registers
   //----------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
         pc <= '0;
      else if (pcEnable)
         pc <= pcNext;
   end

   // phase registers, only the IR holds between fetches
   always_ff @(posedge clk)
   begin
      if (irWrite)
         ir <= memReadData;
      mdr    <= memReadData;
      aReg   <= readData1;
      bReg   <= readData2;
      aluOut <= aluResult;
   end

   //----------------------------------------------------------------------
   // immediates
   //----------------------------------------------------------------------
   assign signImm    = {{16{ir.iFields.imm[15]}}, ir.iFields.imm};
   assign immExt     = (op == isaPkg::opAndi) ? {16'b0, ir.iFields.imm} : signImm;
   assign branchOff  = signImm << 2;
   assign jumpTarget = {pc[31:28], ir.jFields.target, 2'b00};

   assign op           = ir.iFields.op;
   assign memAdr       = iOrD ? aluOut : pc;
   assign memWriteData = bReg;               // sw stores rt
   assign srcAVal      = srcASel ? aReg : pc;

   always_comb
   begin
      case (srcB)
         ctrlPkg::srcBFour:   srcBVal = 32'd4;
         ctrlPkg::srcBImm:    srcBVal = immExt;
         ctrlPkg::srcBBranch: srcBVal = branchOff;
         default:             srcBVal = bReg;
      endcase
   end

   always_comb
   begin
      case (regDst)
         ctrlPkg::dstRd:   writeAdr = ir.rFields.rd;
         ctrlPkg::dstLink: writeAdr = isaPkg::linkReg;
         default:          writeAdr = ir.rFields.rt;
      endcase
   end

   // jal links the already incremented pc
   assign writeData = (regDst == ctrlPkg::dstLink) ? pc : (memToReg ? mdr : aluOut);

   always_comb
   begin
      case (pcSource)
         ctrlPkg::pcAluOut: pcNext = aluOut;     // branch target from decode
         ctrlPkg::pcJump:   pcNext = jumpTarget;
         default:           pcNext = aluResult;
      endcase
   end

   regFile regs
   (
      .clk       (clk),
      .reset     (reset),
      .regWrite  (regWrite),
      .readAdr1  (ir.rFields.rs),
      .readAdr2  (ir.rFields.rt),
      .writeAdr  (writeAdr),
      .writeData (writeData),
      .readData1 (readData1),
      .readData2 (readData2)
   );

   execUnit exec
   (
      .mode    (mode),
      .op      (op),
      .funct   (ir.rFields.funct),
      .shamt   (ir.rFields.shamt),
      .srcA    (srcAVal),
      .srcB    (srcBVal),
      .result  (aluResult),
      .zero    (zero),
      .jrTaken (jrTaken)
   );

endmodule

`default_nettype wire

/* src/mipsCore.sv */
// multicycle MIPS subset core
// control FSM and datapath joined to the memory ports
`timescale 1ns/10ps
`default_nettype none

module mipsCore
(
   input  wire logic                         clk,
   input  wire logic                         reset,
   input  wire logic [isaPkg::dataWidth-1:0] memReadData,
   output logic [isaPkg::dataWidth-1:0]      memAdr,
   output logic [isaPkg::dataWidth-1:0]      memWriteData,
   output logic                              memRead,
   output logic                              memWrite
);

   logic               irWrite, regWrite, memToReg, iOrD, srcASel, pcEnable;
   logic               zero, jrTaken;
   logic [5:0]         op;
   ctrlPkg::regDstSel  regDst;
   ctrlPkg::srcBSel    srcB;
   ctrlPkg::pcSel      pcSource;
   ctrlPkg::aluMode    mode;

   mainControl ctrl
   (
      .clk      (clk),
      .reset    (reset),
      .op       (op),
      .zero     (zero),
      .jrTaken  (jrTaken),
      .memRead  (memRead),
      .memWrite (memWrite),
      .irWrite  (irWrite),
      .regWrite (regWrite),
      .memToReg (memToReg),
      .iOrD     (iOrD),
      .srcASel  (srcASel),
      .regDst   (regDst),
      .srcB     (srcB),
      .pcSource (pcSource),
      .mode     (mode),
      .pcEnable (pcEnable)
   );

   datapath dp
   (
      .clk          (clk),
      .reset        (reset),
      .memReadData  (memReadData),
      .irWrite      (irWrite),
      .regWrite     (regWrite),
      .memToReg     (memToReg),
      .iOrD         (iOrD),
      .srcASel      (srcASel),
      .pcEnable     (pcEnable),
      .regDst       (regDst),
      .srcB         (srcB),
      .pcSource     (pcSource),
      .mode         (mode),
      .op           (op),
      .zero         (zero),
      .jrTaken      (jrTaken),
      .memAdr       (memAdr),
      .memWriteData (memWriteData)
   );

endmodule

`default_nettype wire

/* sim/programTests.svh */
// directed program tests for the core
// arithmetic, load/store, branches, jumps, shifts and lui

task automatic arithmeticTest();
   logic [31:0] a, b;
   logic [15:0] immA, immB;
   a    = $random(seed);
   b    = $random(seed);
   immA = 16'($random(seed));
   immB = 16'($random(seed)) | 16'h8000;   // top bit set, zero extension must show
   fillMemory();
   mem[6'd40] = a;
   mem[6'd41] = b;
   place(immInstr(isaPkg::opLw, 0, 1, dataAdr));
   place(immInstr(isaPkg::opLw, 0, 2, dataAdr + 4));
   place(regInstr(isaPkg::fnAdd, 1, 2, 3, 0));
   place(regInstr(isaPkg::fnSub, 1, 2, 4, 0));
   place(regInstr(isaPkg::fnAnd, 1, 2, 5, 0));
   place(regInstr(isaPkg::fnOr, 1, 2, 6, 0));
   place(immInstr(isaPkg::opAddi, 1, 7, immA));
   place(immInstr(isaPkg::opAndi, 1, 8, immB));
   for (int k = 0; k < 6; k++)
      place(immInstr(isaPkg::opSw, 0, 3 + k, outAdr + 4 * k)); // $3..$8 out
   runProgram();
   checkValue("add result", resultAt(0), a + b);
   checkValue("sub result", resultAt(1), a - b);
   checkValue("and result", resultAt(2), a & b);
   checkValue("or result", resultAt(3), a | b);
   checkValue("addi result", resultAt(4), a + {{16{immA[15]}}, immA});
   checkValue("andi result", resultAt(5), a & {16'h0, immB});
endtask

task automatic loadStoreTest();
   logic [31:0] src [4];
   fillMemory();
   for (int k = 0; k < 4; k++)
   begin
      src[k] = $random(seed);
      mem[6'(40 + k)] = src[k];
      place(immInstr(isaPkg::opLw, 0, 1 + k, dataAdr + 4 * k));
   end
   for (int k = 0; k < 4; k++)
      place(immInstr(isaPkg::opSw, 0, 1 + k, outAdr + 4 * k));
   place(immInstr(isaPkg::opLw, 0, 0, dataAdr));        // load into $0
   place(immInstr(isaPkg::opSw, 0, 0, outAdr + 16));
   runProgram();
   for (int k = 0; k < 4; k++)
      checkValue($sformatf("copy of word %0d", k), resultAt(k), src[k]);
   checkValue("store of register 0", resultAt(4), 32'h0);
endtask

// each path stores its own marker, wrong paths store $9
task automatic branchTest();
   logic [31:0] x, y;
   x = $random(seed);
   y = x ^ ($random(seed) | 32'h1);   // never equal to x
   fillMemory();
   mem[6'd40] = x;
   mem[6'd41] = x;
   mem[6'd42] = y;
   place(immInstr(isaPkg::opLw, 0, 1, dataAdr));
   place(immInstr(isaPkg::opLw, 0, 2, dataAdr + 4));
   place(immInstr(isaPkg::opLw, 0, 3, dataAdr + 8));
   place(immInstr(isaPkg::opAddi, 0, 9, 16'h99));
   for (int k = 0; k < 4; k++)
      place(immInstr(isaPkg::opAddi, 0, 11 + k, 17 * (k + 1)));
   place(immInstr(isaPkg::opBeq, 1, 2, 1));             // taken
   place(immInstr(isaPkg::opSw, 0, 9, outAdr + 16));
   place(immInstr(isaPkg::opSw, 0, 11, outAdr));
   place(immInstr(isaPkg::opBeq, 1, 3, 1));             // not taken
   place(immInstr(isaPkg::opSw, 0, 12, outAdr + 4));
   place(immInstr(isaPkg::opBne, 1, 3, 1));             // taken
   place(immInstr(isaPkg::opSw, 0, 9, outAdr + 20));
   place(immInstr(isaPkg::opSw, 0, 13, outAdr + 8));
   place(immInstr(isaPkg::opBne, 1, 2, 1));             // not taken
   place(immInstr(isaPkg::opSw, 0, 14, outAdr + 12));
   runProgram();
   checkValue("beq taken marker", resultAt(0), 32'h11);
   checkValue("beq not-taken marker", resultAt(1), 32'h22);
   checkValue("bne taken marker", resultAt(2), 32'h33);
   checkValue("bne not-taken marker", resultAt(3), 32'h44);
   checkValue("store skipped by beq", resultAt(4), fillWord(52));
   checkValue("store skipped by bne", resultAt(5), fillWord(53));
endtask

task automatic jumpTest();
   logic [15:0] marker;
   logic [31:0] jalAdr;
   marker = 16'($random(seed)) & 16'h7fff;
   fillMemory();
   place(immInstr(isaPkg::opAddi, 0, 5, marker));
   place(jumpInstr(isaPkg::opJ, 3));
   place(immInstr(isaPkg::opSw, 0, 5, outAdr));        // skipped
   jalAdr = 32'(progIdx) * 4;
   place(jumpInstr(isaPkg::opJal, 6));
   place(immInstr(isaPkg::opSw, 0, 5, outAdr + 4));    // return point of jr
   place(jumpInstr(isaPkg::opJ, 8));                   // on to the done store
   place(immInstr(isaPkg::opSw, 0, 31, outAdr + 8));   // subroutine
   place(regInstr(isaPkg::fnJr, 31, 0, 0, 0));
   runProgram();
   checkValue("store skipped by j", resultAt(0), fillWord(48));
   checkValue("store after jr return", resultAt(1), {16'h0, marker});
   checkValue("jal link register", resultAt(2), jalAdr + 32'd4);
endtask

task automatic shiftLuiTest();
   logic [31:0] v;
   logic [15:0] upper;
   int          shl;
   int          shr;
   v     = $random(seed);
   shl   = $random(seed) & 31;
   shr   = $random(seed) & 31;
   upper = 16'($random(seed));
   fillMemory();
   mem[6'd40] = v;
   place(immInstr(isaPkg::opLw, 0, 1, dataAdr));
   place(regInstr(isaPkg::fnSll, 0, 1, 2, shl));
   place(regInstr(isaPkg::fnSrl, 0, 1, 3, shr));
   place(immInstr(isaPkg::opLui, 0, 4, upper));
   for (int k = 0; k < 3; k++)
      place(immInstr(isaPkg::opSw, 0, 2 + k, outAdr + 4 * k));
   runProgram();
   checkValue("sll result", resultAt(0), v << shl);
   checkValue("srl result", resultAt(1), v >> shr);
   checkValue("lui result", resultAt(2), {upper, 16'h0});
endtask

/* sim/tbMips.sv */
// testbench top for the multicycle MIPS subset core
// clock, reset, 64-word memory model, value check, watchdog and test sequence
`timescale 1ns/10ps
`default_nettype none

module tbMips;

   localparam int clkPeriod   = 4;
   localparam int resetCycles = 16;
   localparam int numTests    = 5;
   localparam int maxInstr    = 200;   // instructions allowed per test
   localparam int maxCycles   = 5;     // lw is the longest instruction
   localparam int timeoutNs   = numTests * (maxInstr * maxCycles + resetCycles) * clkPeriod;

   localparam logic [15:0] dataAdr = 16'd160;  // operands from word 40
   localparam logic [15:0] outAdr  = 16'd192;  // results from word 48
   localparam logic [15:0] doneAdr = 16'd252;  // last word of memory

   logic        clk   = 1'b0;
   logic        reset = 1'b1;
   logic [31:0] memReadData;
   logic [31:0] memAdr;
   logic [31:0] memWriteData;
   logic        memRead;
   logic        memWrite;

   logic [31:0] mem [64];
   logic [5:0]  progIdx;                  // next program word
   integer      seed = 32'ha492e8e8;

   always #(clkPeriod / 2) clk = ~clk;

   assign memReadData = mem[memAdr[7:2]]; // same-cycle read

   mipsCore dut
   (
      .clk          (clk),
      .reset        (reset),
      .memReadData  (memReadData),
      .memAdr       (memAdr),
      .memWriteData (memWriteData),
      .memRead      (memRead),
      .memWrite     (memWrite)
   );

   //----------------------------------------------------------------------
   // instruction encoding
   //----------------------------------------------------------------------
   function automatic logic [31:0] regInstr(input logic [5:0] funct, input int rs, rt, rd, shamt);
      return {isaPkg::opRtype, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct};
   endfunction

   function automatic logic [31:0] immInstr(input logic [5:0] op, input int rs, rt, imm);
      return {op, rs[4:0], rt[4:0], imm[15:0]};
   endfunction

   function automatic logic [31:0] jumpInstr(input logic [5:0] op, input int target);
      return {op, target[25:0]};      // word index of the target
   endfunction

   //----------------------------------------------------------------------
   // memory handling
   //----------------------------------------------------------------------
   function automatic logic [31:0] fillWord(input int i);
      return 32'hdead0000 | (i << 2);  // unknown opcode tagged with its byte address
   endfunction

   function automatic logic [31:0] resultAt(input int k);
      return mem[6'(48 + k)];
   endfunction

   task automatic fillMemory();
      for (int i = 0; i < 64; i++)
         mem[6'(i)] = fillWord(i);
      progIdx = '0;
   endtask

   task automatic place(input logic [31:0] instr);
      mem[progIdx] = instr;
      progIdx = progIdx + 6'd1;
   endtask

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected)
         abortRun($sformatf("Mismatch at %0d ns: %s is %h, expected %h",
                            $time, name, actual, expected));
   endtask

   //----------------------------------------------------------------------
   // running a program
   //----------------------------------------------------------------------
   task automatic resetCore();
      @(posedge clk);
      #1;
      reset = 1'b1;
      repeat (resetCycles) @(posedge clk);
      #1;
      reset = 1'b0;
      checkValue("memRead after reset", memRead, 32'h1); // first fetch
      checkValue("memAdr after reset", memAdr, 32'h0);
   endtask

   // runs the core until it stores to doneAdr
   task automatic runUntilDone();
      logic        done;
      logic [31:0] storeAdr;
      logic [31:0] storeData;
      done = 1'b0;
      while (!done)
      begin
         @(negedge clk);
         if (memWrite)
         begin
            storeAdr  = memAdr;
            storeData = memWriteData;
            checkValue("memRead during store", memRead, 32'h0);
            if (storeAdr > 32'd255)
               abortRun($sformatf("store to address %h lies outside the memory", storeAdr));
            else
            begin
               @(posedge clk);    // memory takes the word on this edge
               #1;
               mem[storeAdr[7:2]] = storeData;
               done = (storeAdr == 32'(doneAdr));
            end
         end
      end
   endtask

   // done store followed by a self jump
   task automatic runProgram();
      place(immInstr(isaPkg::opSw, 0, 0, doneAdr));
      place(jumpInstr(isaPkg::opJ, progIdx));
      resetCore();
      runUntilDone();
   endtask

`include "programTests.svh"

   initial
   begin
      #(timeoutNs);
      abortRun("test timed out: program never reached done address");
   end

   initial
   begin
      fillMemory();
      arithmeticTest();
      loadStoreTest();
      branchTest();
      jumpTest();
      shiftLuiTest();
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

/* mipsCore.f */
+incdir+sim
src/isaPkg.sv
src/ctrlPkg.sv
src/regFile.sv
src/execUnit.sv
src/mainControl.sv
src/datapath.sv
src/mipsCore.sv
sim/tbMips.sv

/* run.sh */
#!/usr/bin/env bash
# builds the multicycle core and its testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbMips -f mipsCore.f -o simMips \
   && { ./obj_dir/simMips | tee /dev/stderr | grep -qx "all tests passed"; } \
   && echo "simulation result: PASS" \
   || { echo "simulation result: FAIL"; exit 1; }
